// ==== Makefile ====
# Verilator build and run; override any variable on the command line
VERILATOR       ?= verilator
TOP             ?= serial_alu_tb
SIM_DIR         ?= obj_dir
FILELIST        ?= sources.f
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)
	./$(SIM_DIR)/V$(TOP)

clean:
	rm -rf $(SIM_DIR)

// ==== hdl/nibble_alu.sv ====
// combinational 4-bit ALU for one nibble; INC ignores d2 and the logic ops always return carry 0
`timescale 1ns/1ps

module nibble_alu
    import nibble_alu_pkg::*;
(
    input  nibble_args_t args,
    output nibble_ret_t  ret
);

    // bit 4 of each sum is the carry out of the nibble
    logic [4:0] sum_add;
    logic [4:0] sum_sub;
    logic [4:0] sum_inc;

    assign sum_add = {1'b0, args.d1} + {1'b0, args.d2} + {4'b0000, args.carry_in};

    // subtract as d1 + ~d2 + carry, carry high means no borrow
    assign sum_sub = {1'b0, args.d1} + {1'b0, ~args.d2} + {4'b0000, args.carry_in};

    assign sum_inc = {1'b0, args.d1} + {4'b0000, args.carry_in};

    always_comb begin
        ret.res       = args.d1;
        ret.carry_out = 1'b0;
        case (args.op)
            OP_ADD: begin
                ret.res       = sum_add[3:0];
                ret.carry_out = sum_add[4];
            end
            OP_SUB: begin
                ret.res       = sum_sub[3:0];
                ret.carry_out = sum_sub[4];
            end
            OP_AND: begin
                ret.res = args.d1 & args.d2;
            end
            OP_OR: begin
                ret.res = args.d1 | args.d2;
            end
            OP_XOR: begin
                ret.res = args.d1 ^ args.d2;
            end
            OP_SHR1: begin
                // bit from the nibble above enters at the top
                ret.res       = {args.carry_in, args.d1[3:1]};
                ret.carry_out = args.d1[0];
            end
            OP_SHL1: begin
                // bit from the nibble below enters at the bottom
                ret.res       = {args.d1[2:0], args.carry_in};
                ret.carry_out = args.d1[3];
            end
            OP_INC: begin
                ret.res       = sum_inc[3:0];
                ret.carry_out = sum_inc[4];
            end
            default: begin
                ret.res       = args.d1;
                ret.carry_out = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/nibble_alu_pkg.sv ====
// operation codes are 3 bits and shared with the stimulus file; do not reorder the enum
package nibble_alu_pkg;

    // codes 0..7, same order as the stimulus file uses
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SHR1 = 3'd5,
        OP_SHL1 = 3'd6,
        OP_INC  = 3'd7
    } alu_op_e;

    // one data nibble
    typedef logic [3:0] nibble_t;

    // input of the nibble ALU, 12 bits
    typedef struct packed {
        alu_op_e op;
        nibble_t d1;
        // unused by INC and the shifts
        nibble_t d2;
        // carry from the previous nibble, or shift bit for SHR1/SHL1
        logic    carry_in;
    } nibble_args_t;

    // output of the nibble ALU, 5 bits
    typedef struct packed {
        nibble_t res;
        // carry, no-borrow flag for SUB, or bit shifted out
        logic    carry_out;
    } nibble_ret_t;

endpackage

// ==== hdl/nibble_counter.sv ====
// nibble index counter; direction is sampled only on start and advance past the last nibble is illegal
`timescale 1ns/1ps

module nibble_counter #(
    parameter int NIBBLES = 8,
    localparam int CNT_W = (NIBBLES > 1) ? $clog2(NIBBLES) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             advance,
    input  logic             reverse,
    output logic [CNT_W-1:0] idx,
    output logic             last
);

    localparam logic [CNT_W-1:0] IDX_MAX = CNT_W'(NIBBLES - 1);

    // direction held for the whole word
    logic rev_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            rev_q <= 1'b0;
        end else if (start) begin
            // reverse walks from the top nibble down
            idx   <= reverse ? IDX_MAX : '0;
            rev_q <= reverse;
        end else if (advance) begin
            if (rev_q) begin
                idx <= idx - 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    assign last = rev_q ? (idx == '0) : (idx == IDX_MAX);

    // index must stay inside the word, also for non power-of-two NIBBLES
    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        idx <= IDX_MAX
    ) else $error("nibble index %0d out of range", idx);

    // the sequencer must stop stepping once the final nibble is reached
    a_no_advance_past_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(advance && last && !start)
    ) else $error("advance requested past the last nibble");

endmodule

// ==== hdl/nibble_sequencer.sv ====
// one command in flight at a time; results are held until out_ready and in_ready stays low meanwhile
`timescale 1ns/1ps

module nibble_sequencer
    import nibble_alu_pkg::*;
#(
    parameter int NIBBLES = 8,
    localparam int CNT_W = (NIBBLES > 1) ? $clog2(NIBBLES) : 1
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  alu_op_e                in_op,
    input  logic [4*NIBBLES-1:0]   in_a,
    input  logic [4*NIBBLES-1:0]   in_b,

    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [4*NIBBLES-1:0]   out_result,
    output logic                   out_carry,

    output nibble_args_t           alu_args,
    input  nibble_ret_t            alu_ret,

    output logic                   cnt_start,
    output logic                   cnt_advance,
    output logic                   cnt_reverse,
    input  logic [CNT_W-1:0]       cnt_idx,
    input  logic                   cnt_last
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_nxt;

    alu_op_e op_q;
    logic    carry_q;

    // word registers split into nibbles for indexed access
    nibble_t [NIBBLES-1:0] a_q;
    nibble_t [NIBBLES-1:0] b_q;
    nibble_t [NIBBLES-1:0] res_q;

    logic accept;
    logic finish;

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == DONE);
    assign accept    = in_valid && in_ready;

    // INC stops at the first nibble that does not overflow
    assign finish = cnt_last || ((op_q == OP_INC) && !alu_ret.carry_out);

    assign cnt_start   = accept;
    assign cnt_advance = (state == RUN) && !finish;
    // the counter samples direction on start before op_q holds the new command
    assign cnt_reverse = in_ready ? (in_op == OP_SHR1) : (op_q == OP_SHR1);

    assign alu_args = '{
        op:       op_q,
        d1:       a_q[cnt_idx],
        d2:       b_q[cnt_idx],
        carry_in: carry_q
    };

    assign out_result = res_q;
    // last carry_out produced stays in carry_q
    assign out_carry  = carry_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (in_valid) state_nxt = RUN;
            RUN:  if (finish) state_nxt = DONE;
            DONE: if (out_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            op_q    <= OP_ADD;
            carry_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                op_q <= in_op;
                // SUB and INC need a +1 on the first nibble
                carry_q <= (in_op == OP_SUB) || (in_op == OP_INC);
            end else if (state == RUN) begin
                carry_q <= alu_ret.carry_out;
            end
        end
    end

    // operand and result storage
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q   <= in_a;
            b_q   <= in_b;
            // INC leaves unvisited nibbles equal to a
            res_q <= in_a;
        end else if (state == RUN) begin
            res_q[cnt_idx] <= alu_ret.res;
        end
    end

    // result must not move under back-pressure
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_result) && $stable(out_carry)
    ) else $error("result changed while waiting for out_ready");

    // first nibble is the top one for SHR1 and the bottom one for the rest
    a_start_nibble: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |=> cnt_idx == ((op_q == OP_SHR1) ? CNT_W'(NIBBLES - 1) : CNT_W'(0))
    ) else $error("counter did not start at the first nibble for the operation");

endmodule

// ==== hdl/serial_alu_top.sv ====
// nibble-serial 32-bit ALU by default; word width is 4*NIBBLES and only one command runs at a time
`timescale 1ns/1ps

module serial_alu_top
    import nibble_alu_pkg::*;
#(
    parameter int NIBBLES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_op_e              in_op,
    input  logic [4*NIBBLES-1:0] in_a,
    input  logic [4*NIBBLES-1:0] in_b,

    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [4*NIBBLES-1:0] out_result,
    output logic                 out_carry
);

    localparam int CNT_W = (NIBBLES > 1) ? $clog2(NIBBLES) : 1;

    nibble_args_t     alu_args;
    nibble_ret_t      alu_ret;
    logic             cnt_start;
    logic             cnt_advance;
    logic             cnt_reverse;
    logic [CNT_W-1:0] cnt_idx;
    logic             cnt_last;

    nibble_sequencer #(
        .NIBBLES (NIBBLES)
    ) u_nibble_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_a        (in_a),
        .in_b        (in_b),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_carry   (out_carry),
        .alu_args    (alu_args),
        .alu_ret     (alu_ret),
        .cnt_start   (cnt_start),
        .cnt_advance (cnt_advance),
        .cnt_reverse (cnt_reverse),
        .cnt_idx     (cnt_idx),
        .cnt_last    (cnt_last)
    );

    nibble_counter #(
        .NIBBLES (NIBBLES)
    ) u_nibble_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (cnt_start),
        .advance (cnt_advance),
        .reverse (cnt_reverse),
        .idx     (cnt_idx),
        .last    (cnt_last)
    );

    // a single ALU instance serves every nibble of the word
    nibble_alu u_nibble_alu (
        .args (alu_args),
        .ret  (alu_ret)
    );

endmodule

// ==== sources.f ====
hdl/nibble_alu_pkg.sv
hdl/nibble_alu.sv
hdl/nibble_counter.sv
hdl/nibble_sequencer.sv
hdl/serial_alu_top.sv
tests/serial_alu_tb.sv

// ==== tests/serial_alu_stimulus.txt ====
# columns: op a b expected_result expected_carry, all hex
# op: 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SHR1, 6 SHL1, 7 INC
0 efffffff 00000001 f0000000 0
0 ffff0fff 00000002 ffff1001 0
0 ffffffff 00000001 00000000 1
0 12345678 87654321 99999999 0
0 80000000 80000000 00000000 1
0 00000000 00000000 00000000 0
1 00000005 00000003 00000002 1
1 00000003 00000005 fffffffe 0
1 12345678 12345678 00000000 1
1 00000000 00000001 ffffffff 0
1 f0000000 0fffffff e0000001 1
2 a5c396f0 3c5a0ff3 244206f0 0
2 deadbeef ffff0000 dead0000 0
3 a5c396f0 3c5a0ff3 bddb9ff3 0
3 00ff00ff f0f0f0f0 f0fff0ff 0
4 a5c396f0 3c5a0ff3 99999903 0
4 deadbeef deadbeef 00000000 0
5 06000000 00000000 03000000 0
5 00000001 00000000 00000000 1
5 80000001 00000000 40000000 1
5 fedcba98 00000000 7f6e5d4c 0
6 80000000 00000000 00000000 1
6 12345678 00000000 2468acf0 0
6 c0000001 00000000 80000002 1
7 00000000 00000000 00000001 0
7 0000000f 00000000 00000010 0
7 00000fff 00000000 00001000 0
7 1234f0ff 00000000 1234f100 0
7 fffffff0 00000000 fffffff1 0
7 0fffffff 00000000 10000000 0
7 ffffffff 00000000 00000000 1

// ==== tests/serial_alu_tb.sv ====
// run from the project root so the stimulus path resolves; the checks assume an 8-nibble (32-bit) word
`timescale 1ns/1ps

module serial_alu_tb
    import nibble_alu_pkg::*;
();

    localparam int    NIBBLES   = 8;
    localparam int    WIDTH     = 4 * NIBBLES;
    localparam int    TIMEOUT   = 100;
    localparam string STIM_FILE = "tests/serial_alu_stimulus.txt";

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    alu_op_e          in_op;
    logic [WIDTH-1:0] in_a;
    logic [WIDTH-1:0] in_b;
    logic             out_valid;
    logic             out_ready = 1'b0;
    logic [WIDTH-1:0] out_result;
    logic             out_carry;

    integer      seed = 32'ha1b5_4c8d;
    logic [31:0] rnd;

    always #2 clk = ~clk;

    // random back-pressure that is high about half the time
    always @(posedge clk) begin
        rnd = $random(seed);
        out_ready <= rnd[0];
    end

    serial_alu_top #(
        .NIBBLES (NIBBLES)
    ) u_serial_alu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_carry  (out_carry)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // INC takes one cycle plus one per low F nibble and all others take the full word
    function automatic int expected_latency(input alu_op_e op, input logic [WIDTH-1:0] a);
        int lat;
        int i;
        lat = NIBBLES;
        if (op == OP_INC) begin
            lat = 1;
            for (i = 0; i < NIBBLES - 1; i++) begin
                if (a[4*i +: 4] != 4'hf) begin
                    break;
                end
                lat++;
            end
        end
        return lat;
    endfunction

    // called on a rising edge; returns right after the accepting edge
    task automatic send_command(input alu_op_e op, input logic [WIDTH-1:0] a,
                                input logic [WIDTH-1:0] b);
        int waited;
        in_valid <= 1'b1;
        in_op    <= op;
        in_a     <= a;
        in_b     <= b;
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited >= TIMEOUT) begin
                abort_run("command handshake stalled: in_ready stayed low for 100 cycles");
            end
            @(negedge clk);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // counts cycles from the accepting edge and then holds the result under back-pressure
    task automatic collect_result(input alu_op_e op, input logic [WIDTH-1:0] a,
                                  input logic [WIDTH-1:0] exp_res, input logic exp_carry,
                                  input string tag);
        int               lat;
        int               waited;
        logic [WIDTH-1:0] held_res;
        logic             held_carry;
        lat = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_equal(32'(in_ready), 32'd0, {tag, ": in_ready while busy"});
            lat++;
            if (lat >= TIMEOUT) begin
                abort_run("result handshake stalled: out_valid stayed low for 100 cycles");
            end
            @(negedge clk);
        end
        check_equal(32'(lat), 32'(expected_latency(op, a)), {tag, ": latency"});
        check_equal(out_result, exp_res, {tag, ": result"});
        check_equal(32'(out_carry), 32'(exp_carry), {tag, ": carry"});
        held_res   = out_result;
        held_carry = out_carry;

        waited = 0;
        while (!out_ready) begin
            check_equal(32'(in_ready), 32'd0, {tag, ": in_ready while result pending"});
            @(negedge clk);
            check_equal(32'(out_valid), 32'd1, {tag, ": out_valid under back-pressure"});
            check_equal(out_result, held_res, {tag, ": result held"});
            check_equal(32'(out_carry), 32'(held_carry), {tag, ": carry held"});
            waited++;
            if (waited >= TIMEOUT) begin
                abort_run("result handshake stalled: out_ready stayed low for 100 cycles");
            end
        end
        // after the handshake edge the unit must be idle again
        @(posedge clk);
        @(negedge clk);
        check_equal(32'(out_valid), 32'd0, {tag, ": out_valid after handshake"});
        check_equal(32'(in_ready), 32'd1, {tag, ": in_ready after handshake"});
        @(posedge clk);
    endtask

    initial begin
        int          fd;
        int          fields;
        int          count;
        string       line;
        string       tag;
        alu_op_e     op;
        logic [31:0] op_word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_res;
        logic [31:0] exp_carry;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_a     = '0;
        in_b     = '0;
        count    = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file tests/serial_alu_stimulus.txt");
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal(32'(out_valid), 32'd0, "out_valid after reset");
        check_equal(32'(in_ready), 32'd1, "in_ready after reset");
        @(posedge clk);

        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // skip comments and blank lines
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h", op_word, a, b, exp_res, exp_carry);
            if (fields != 5 || op_word > 32'd7 || exp_carry > 32'd1) begin
                abort_run($sformatf("malformed stimulus line: %s", line));
            end
            op  = alu_op_e'(op_word[2:0]);
            tag = $sformatf("%s a=%h b=%h", op.name(), a, b);
            send_command(op, a, b);
            collect_result(op, a, exp_res, exp_carry[0], tag);
            count++;
        end
        $fclose(fd);

        if (count == 0) begin
            abort_run("the stimulus file holds no commands");
        end else begin
            $display("%0d commands checked", count);
            $display("Everything OK");
            $finish;
        end
    end

endmodule
